//--- drone_rate_ctrl.f
source/rate_ctrl_pkg.sv
source/pid_axis.sv
source/body_frame_controller.sv
source/gain_regs.sv
source/rate_ctrl_top.sv
verification/rate_ctrl_assert.sv
verification/rate_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the drone rate controller

VERILATOR ?= verilator
TOP       ?= rate_ctrl_tb
FILELIST  ?= drone_rate_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/rate_ctrl_tb.sv
// Self-checking testbench with its own PID model; assumes zero-wait APB and a seven-cycle step
`timescale 1ns/1ps

module rate_ctrl_tb;
	import rate_ctrl_pkg::*;

	localparam int DONE_TIMEOUT = 40;
	localparam int APB_TIMEOUT = 8;

	logic us_clk;
	logic resetn;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic start;
	logic done;
	rate_t yaw_target, roll_target, pitch_target;
	rate_t yaw_rotation, roll_rotation, pitch_rotation;
	rate_t yaw_rate_out, roll_rate_out, pitch_rate_out;

	int errors = 0;
	int test_base = 0;
	int tests_run = 0;
	int tests_failed = 0;
	integer seed = 87220;
	longint cycles = 0;
	longint start_edge = 0;

	// Model state per axis in yaw, roll and pitch order
	longint m_kp[3];
	longint m_ki[3];
	longint m_kd[3];
	longint m_integ[3] = '{0, 0, 0};
	longint m_prev[3] = '{0, 0, 0};
	longint exp_out[3];
	int row_tgt[3];
	int row_rot[3];

	apb_data_t reset_gains[3] = '{32'h0005_0033, 32'h0004_0305, 32'h0004_0305};

	// Proportional rows with kp 16, 32 and 8; expected outputs by hand
	int p_tgt[5][3] = '{'{160, 100, -50}, '{0, -16, 7}, '{3, 0, -7},
		'{3000, 2500, -20000}, '{-30000, -30000, 30000}};
	int p_rot[5][3] = '{'{32, 40, 30}, '{-80, 17, 0}, '{0, 0, 0},
		'{2000, -100, -20000}, '{-30000, 30000, 30000}};
	int p_exp[5][3] = '{'{192, 120, -10}, '{-80, -66, 3}, '{3, 0, -4},
		'{4000, 4000, -4000}, '{-4000, -4000, 4000}};

	// Full PID rows with repeat counts
	// Row 3 saturates the roll and pitch integrators and row 4 winds them back below the clamp
	int f_tgt[7][3] = '{'{400, 320, -240}, '{400, 320, -240}, '{-800, -160, 480},
		'{0, 32000, -32000}, '{0, -32000, 32000}, '{1600, -1600, 1600}, '{0, 0, 0}};
	int f_rot[7][3] = '{'{-100, 80, 60}, '{-60, 200, -30}, '{120, -300, 200},
		'{0, -32000, -32000}, '{0, 32000, 32000}, '{-1600, 1600, 1600}, '{0, 0, 0}};
	int f_rep[7] = '{1, 1, 2, 18, 16, 2, 1};

	rate_ctrl_top i_dut (.*);

	bind rate_ctrl_top rate_ctrl_assert i_assert (
		.us_clk(us_clk), .resetn(resetn), .psel(psel), .penable(penable), .pready(pready),
		.start(start), .done(done), .yaw_rate_out(yaw_rate_out),
		.roll_rate_out(roll_rate_out), .pitch_rate_out(pitch_rate_out)
	);

	always #20 us_clk = ~us_clk;

	always @(posedge us_clk)
		cycles <= cycles + 1;

	task automatic check_value(input string what, input logic signed [63:0] got,
		input logic signed [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_base) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name, errors - test_base);
		end
		test_base = errors;
	endtask

	task automatic apb_access(input apb_addr_t addr, input logic write, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		int waited;
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge us_clk);
		penable = 1'b1;
		waited = 0;
		#1;
		while (!pready && waited < APB_TIMEOUT) begin
			@(negedge us_clk);
			#1;
			waited++;
		end
		if (!pready) begin
			$display("TIMEOUT: APB slave never raised pready for address %h", addr);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge us_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		apb_data_t ignored;
		apb_access(addr, 1'b1, data, ignored, err);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		apb_access(addr, 1'b0, '0, data, err);
	endtask

	task automatic write_gains(input int axis, input int kp, input int ki, input int kd);
		logic err;
		apb_write(apb_addr_t'(axis * 4), {8'h00, 8'(kd), 8'(ki), 8'(kp)}, err);
		check_value("pslverr on gain write", err, 0);
	endtask

	task automatic set_model_gains(input int axis, input int kp, input int ki, input int kd);
		m_kp[axis] = kp;
		m_ki[axis] = ki;
		m_kd[axis] = kd;
	endtask

	task automatic clear_integrators();
		logic err;
		int a;
		apb_write(REG_CTRL, 32'h1, err);
		for (a = 0; a < 3; a++) begin
			m_integ[a] = 0;
			m_prev[a] = 0;
		end
	endtask

	// Yaw and pitch IMU axes are mounted reversed
	function automatic longint body_actual(input int axis, input int rot);
		rate_t raw;
		rate_t flipped;
		raw = rate_t'(rot);
		flipped = -raw;
		if (axis == 1)
			return raw;
		else
			return flipped;
	endfunction

	function automatic longint model_step(input int axis, input longint target,
		input longint actual);
		longint err;
		longint deriv;
		longint sum;
		err = target - actual;
		m_integ[axis] = m_integ[axis] + err;
		if (m_integ[axis] > INTEG_LIMIT)
			m_integ[axis] = INTEG_LIMIT;
		else if (m_integ[axis] < -INTEG_LIMIT)
			m_integ[axis] = -INTEG_LIMIT;
		deriv = err - m_prev[axis];
		m_prev[axis] = err;
		sum = ((m_kp[axis] * err) >>> GAIN_SHIFT) + ((m_ki[axis] * m_integ[axis]) >>> GAIN_SHIFT)
			+ ((m_kd[axis] * deriv) >>> GAIN_SHIFT);
		if (sum > RATE_LIMIT)
			sum = RATE_LIMIT;
		else if (sum < -RATE_LIMIT)
			sum = -RATE_LIMIT;
		return sum;
	endfunction

	task automatic predict_outputs();
		int a;
		for (a = 0; a < 3; a++)
			exp_out[a] = model_step(a, rate_t'(row_tgt[a]), body_actual(a, row_rot[a]));
	endtask

	task automatic launch_cycle();
		yaw_target = rate_t'(row_tgt[0]);
		roll_target = rate_t'(row_tgt[1]);
		pitch_target = rate_t'(row_tgt[2]);
		yaw_rotation = rate_t'(row_rot[0]);
		roll_rotation = rate_t'(row_rot[1]);
		pitch_rotation = rate_t'(row_rot[2]);
		start = 1'b1;
		start_edge = cycles + 1;
		@(negedge us_clk);
		start = 1'b0;
	endtask

	// Leaves the DUT back in WAITING when done was seen
	task automatic wait_done(output bit seen);
		int waited;
		waited = 0;
		seen = 1'b0;
		while (!done && waited < DONE_TIMEOUT) begin
			@(negedge us_clk);
			waited++;
		end
		if (done) begin
			seen = 1'b1;
			check_value("done latency", cycles - start_edge, 7);
			@(negedge us_clk);
		end else begin
			$display("TIMEOUT: no done pulse within %0d cycles after start", DONE_TIMEOUT);
			errors++;
		end
	endtask

	task automatic compare_outputs(input string tag);
		check_value({tag, " yaw"}, yaw_rate_out, exp_out[0]);
		check_value({tag, " roll"}, roll_rate_out, exp_out[1]);
		check_value({tag, " pitch"}, pitch_rate_out, exp_out[2]);
	endtask

	task automatic run_model_row(input string tag);
		bit seen;
		predict_outputs();
		launch_cycle();
		wait_done(seen);
		if (seen)
			compare_outputs(tag);
	endtask

	initial begin
		apb_data_t rdata;
		apb_data_t wdata;
		logic err;
		bit seen;
		int i;
		int a;
		int r;
		int extra;
		us_clk = 1'b0;
		resetn = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		start = 1'b0;
		yaw_target = '0;
		roll_target = '0;
		pitch_target = '0;
		yaw_rotation = '0;
		roll_rotation = '0;
		pitch_rotation = '0;
		set_model_gains(0, 51, 0, 5);
		set_model_gains(1, 5, 3, 4);
		set_model_gains(2, 5, 3, 4);
		repeat (5) @(negedge us_clk);
		resetn = 1'b1;
		@(negedge us_clk);

		check_value("done after reset", done, 0);
		check_value("yaw out after reset", yaw_rate_out, 0);
		check_value("roll out after reset", roll_rate_out, 0);
		check_value("pitch out after reset", pitch_rate_out, 0);
		for (a = 0; a < 3; a++) begin
			apb_read(apb_addr_t'(a * 4), rdata, err);
			check_value($sformatf("reset gains axis %0d", a), rdata, reset_gains[a]);
		end
		finish_test("reset");

		// Upper byte is not stored
		for (a = 0; a < 3; a++) begin
			wdata = 32'hFF00_0000 | (32'h0010_2030 * (a + 1));
			apb_write(apb_addr_t'(a * 4), wdata, err);
			apb_read(apb_addr_t'(a * 4), rdata, err);
			check_value($sformatf("gain readback axis %0d", a), rdata, wdata & 32'h00FF_FFFF);
		end
		apb_write(12'h010, 32'h00FF_FFFF, err);
		check_value("pslverr on unmapped write", err, 1);
		apb_read(12'h010, rdata, err);
		check_value("pslverr on unmapped read", err, 1);
		check_value("unmapped read data", rdata, 0);
		apb_read(REG_YAW_GAIN, rdata, err);
		check_value("yaw gains after unmapped write", rdata, 32'h0010_2030);
		apb_read(REG_CTRL, rdata, err);
		check_value("control register read", rdata, 0);
		check_value("pslverr on control read", err, 0);
		finish_test("apb registers");

		write_gains(0, 16, 0, 0);
		write_gains(1, 32, 0, 0);
		write_gains(2, 8, 0, 0);
		set_model_gains(0, 16, 0, 0);
		set_model_gains(1, 32, 0, 0);
		set_model_gains(2, 8, 0, 0);
		for (i = 0; i < 5; i++) begin
			row_tgt = p_tgt[i];
			row_rot = p_rot[i];
			predict_outputs();
			for (a = 0; a < 3; a++)
				exp_out[a] = p_exp[i][a];
			launch_cycle();
			wait_done(seen);
			if (seen)
				compare_outputs($sformatf("p row %0d", i));
		end
		finish_test("proportional and sign");

		write_gains(0, 51, 0, 5);
		write_gains(1, 5, 3, 4);
		write_gains(2, 5, 3, 4);
		set_model_gains(0, 51, 0, 5);
		set_model_gains(1, 5, 3, 4);
		set_model_gains(2, 5, 3, 4);
		clear_integrators();
		for (i = 0; i < 7; i++) begin
			row_tgt = f_tgt[i];
			row_rot = f_rot[i];
			for (r = 0; r < f_rep[i]; r++)
				run_model_row($sformatf("pid row %0d.%0d", i, r));
		end
		for (i = 0; i < 12; i++) begin
			for (a = 0; a < 3; a++) begin
				row_tgt[a] = $random(seed) % 4096;
				row_rot[a] = $random(seed) % 4096;
			end
			run_model_row($sformatf("random row %0d", i));
		end
		finish_test("full pid sequence");

		clear_integrators();
		row_tgt = '{300, 300, 300};
		row_rot = '{-50, 50, 50};
		run_model_row("after clear");
		// Roll gain written once go has sampled the old one
		predict_outputs();
		launch_cycle();
		write_gains(1, 40, 2, 9);
		wait_done(seen);
		if (seen)
			compare_outputs("gain mid cycle");
		set_model_gains(1, 40, 2, 9);
		run_model_row("gain next cycle");
		finish_test("clear and gain timing");

		row_tgt = '{200, -200, 100};
		row_rot = '{20, 30, -40};
		predict_outputs();
		launch_cycle();
		@(negedge us_clk);
		yaw_target = rate_t'(-1234);
		roll_rotation = rate_t'(777);
		start = 1'b1;
		@(negedge us_clk);
		start = 1'b0;
		wait_done(seen);
		if (seen)
			compare_outputs("busy start");
		extra = 0;
		repeat (12) begin
			@(negedge us_clk);
			if (done)
				extra++;
		end
		if (extra != 0) begin
			$display("ERROR: %0d extra done pulses after a start sent while busy", extra);
			errors++;
		end
		finish_test("start while busy");

		$display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verification/rate_ctrl_assert.sv
// Bound checks on APB ready, the done pulse and output range; a start counts only while idle
`timescale 1ns/1ps

module rate_ctrl_assert (
	input logic                 us_clk,
	input logic                 resetn,
	input logic                 psel,
	input logic                 penable,
	input logic                 pready,
	input logic                 start,
	input logic                 done,
	input rate_ctrl_pkg::rate_t yaw_rate_out,
	input rate_ctrl_pkg::rate_t roll_rate_out,
	input rate_ctrl_pkg::rate_t pitch_rate_out
);
	import rate_ctrl_pkg::*;

	logic busy;

	function automatic logic in_range(rate_t value);
		return (value <= RATE_LIMIT) && (value >= -RATE_LIMIT);
	endfunction

	// Follows the controller from accepted start to done
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			busy <= 1'b0;
		else if (start && !busy)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

	apb_ready: assert property (@(posedge us_clk) disable iff (!resetn)
		psel && penable |-> pready)
		else $error("pready low in an APB access phase");

	done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// Start taken at edge 0, done rises at edge 7 and is sampled one edge later
	done_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		start && !busy |-> ##8 done)
		else $error("done did not follow an accepted start by seven cycles");

	out_range: assert property (@(posedge us_clk) disable iff (!resetn)
		in_range(yaw_rate_out) && in_range(roll_rate_out) && in_range(pitch_rate_out))
		else $error("rate output beyond the clamp limit");

endmodule

//--- source/rate_ctrl_top.sv
// Rate controller with its APB gain block; callers must wait for done before the next start
`timescale 1ns/1ps

module rate_ctrl_top (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  rate_ctrl_pkg::apb_addr_t paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  rate_ctrl_pkg::apb_data_t pwdata,
	output rate_ctrl_pkg::apb_data_t prdata,
	output logic                     pready,
	output logic                     pslverr,
	input  logic                     start,
	input  rate_ctrl_pkg::rate_t     yaw_target,
	input  rate_ctrl_pkg::rate_t     roll_target,
	input  rate_ctrl_pkg::rate_t     pitch_target,
	input  rate_ctrl_pkg::rate_t     yaw_rotation,
	input  rate_ctrl_pkg::rate_t     roll_rotation,
	input  rate_ctrl_pkg::rate_t     pitch_rotation,
	output logic                     done,
	output rate_ctrl_pkg::rate_t     yaw_rate_out,
	output rate_ctrl_pkg::rate_t     roll_rate_out,
	output rate_ctrl_pkg::rate_t     pitch_rate_out
);
	import rate_ctrl_pkg::*;

	gain_t yaw_kp;
	gain_t yaw_ki;
	gain_t yaw_kd;
	gain_t roll_kp;
	gain_t roll_ki;
	gain_t roll_kd;
	gain_t pitch_kp;
	gain_t pitch_ki;
	gain_t pitch_kd;
	logic clear_integ;

	gain_regs i_gain_regs (
		.us_clk(us_clk), .resetn(resetn),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.yaw_kp(yaw_kp), .yaw_ki(yaw_ki), .yaw_kd(yaw_kd),
		.roll_kp(roll_kp), .roll_ki(roll_ki), .roll_kd(roll_kd),
		.pitch_kp(pitch_kp), .pitch_ki(pitch_ki), .pitch_kd(pitch_kd),
		.clear_integ(clear_integ)
	);

	body_frame_controller i_body_frame_controller (
		.us_clk(us_clk), .resetn(resetn), .start(start),
		.yaw_target(yaw_target), .roll_target(roll_target), .pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation), .roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.yaw_kp(yaw_kp), .yaw_ki(yaw_ki), .yaw_kd(yaw_kd),
		.roll_kp(roll_kp), .roll_ki(roll_ki), .roll_kd(roll_kd),
		.pitch_kp(pitch_kp), .pitch_ki(pitch_ki), .pitch_kd(pitch_kd),
		.clear_integ(clear_integ), .done(done),
		.yaw_rate_out(yaw_rate_out), .roll_rate_out(roll_rate_out),
		.pitch_rate_out(pitch_rate_out)
	);

endmodule

//--- source/gain_regs.sv
// APB gain registers with zero wait states; unaligned mapped addresses read zero and ignore writes
`timescale 1ns/1ps

module gain_regs (
	input  logic                     us_clk,
	input  logic                     resetn,
	input  rate_ctrl_pkg::apb_addr_t paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  rate_ctrl_pkg::apb_data_t pwdata,
	output rate_ctrl_pkg::apb_data_t prdata,
	output logic                     pready,
	output logic                     pslverr,
	output rate_ctrl_pkg::gain_t     yaw_kp,
	output rate_ctrl_pkg::gain_t     yaw_ki,
	output rate_ctrl_pkg::gain_t     yaw_kd,
	output rate_ctrl_pkg::gain_t     roll_kp,
	output rate_ctrl_pkg::gain_t     roll_ki,
	output rate_ctrl_pkg::gain_t     roll_kd,
	output rate_ctrl_pkg::gain_t     pitch_kp,
	output rate_ctrl_pkg::gain_t     pitch_ki,
	output rate_ctrl_pkg::gain_t     pitch_kd,
	output logic                     clear_integ
);
	import rate_ctrl_pkg::*;

	logic access;
	logic bad_addr;
	logic wr_en;

	// kp low byte, then ki, then kd
	function automatic apb_data_t pack_gains(gain_t p, gain_t i, gain_t d);
		return {8'h00, d, i, p};
	endfunction

	assign access = psel && penable;
	assign bad_addr = (paddr > REG_CTRL);
	assign wr_en = access && pwrite && !bad_addr;
	assign pready = 1'b1;
	assign pslverr = access && bad_addr;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_kp <= YAW_KP_RST;
			yaw_ki <= YAW_KI_RST;
			yaw_kd <= YAW_KD_RST;
			roll_kp <= ROLL_KP_RST;
			roll_ki <= ROLL_KI_RST;
			roll_kd <= ROLL_KD_RST;
			pitch_kp <= PITCH_KP_RST;
			pitch_ki <= PITCH_KI_RST;
			pitch_kd <= PITCH_KD_RST;
			clear_integ <= 1'b0;
		end else begin
			// Single-cycle pulse per write
			clear_integ <= wr_en && (paddr == REG_CTRL) && pwdata[0];
			if (wr_en) begin
				case (paddr)
					REG_YAW_GAIN: begin
						yaw_kp <= pwdata[7:0];
						yaw_ki <= pwdata[15:8];
						yaw_kd <= pwdata[23:16];
					end
					REG_ROLL_GAIN: begin
						roll_kp <= pwdata[7:0];
						roll_ki <= pwdata[15:8];
						roll_kd <= pwdata[23:16];
					end
					REG_PITCH_GAIN: begin
						pitch_kp <= pwdata[7:0];
						pitch_ki <= pwdata[15:8];
						pitch_kd <= pwdata[23:16];
					end
					default: ;
				endcase
			end
		end
	end

	// REG_CTRL and unmapped addresses read back zero
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				REG_YAW_GAIN: prdata = pack_gains(yaw_kp, yaw_ki, yaw_kd);
				REG_ROLL_GAIN: prdata = pack_gains(roll_kp, roll_ki, roll_kd);
				REG_PITCH_GAIN: prdata = pack_gains(pitch_kp, pitch_ki, pitch_kd);
				default: prdata = '0;
			endcase
		end
	end

endmodule

//--- source/body_frame_controller.sv
// Rate controller for three axes; start is taken only when idle and done comes seven cycles later
`timescale 1ns/1ps

module body_frame_controller (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 start,
	input  rate_ctrl_pkg::rate_t yaw_target,
	input  rate_ctrl_pkg::rate_t roll_target,
	input  rate_ctrl_pkg::rate_t pitch_target,
	input  rate_ctrl_pkg::rate_t yaw_rotation,
	input  rate_ctrl_pkg::rate_t roll_rotation,
	input  rate_ctrl_pkg::rate_t pitch_rotation,
	input  rate_ctrl_pkg::gain_t yaw_kp,
	input  rate_ctrl_pkg::gain_t yaw_ki,
	input  rate_ctrl_pkg::gain_t yaw_kd,
	input  rate_ctrl_pkg::gain_t roll_kp,
	input  rate_ctrl_pkg::gain_t roll_ki,
	input  rate_ctrl_pkg::gain_t roll_kd,
	input  rate_ctrl_pkg::gain_t pitch_kp,
	input  rate_ctrl_pkg::gain_t pitch_ki,
	input  rate_ctrl_pkg::gain_t pitch_kd,
	input  logic                 clear_integ,
	output logic                 done,
	output rate_ctrl_pkg::rate_t yaw_rate_out,
	output rate_ctrl_pkg::rate_t roll_rate_out,
	output rate_ctrl_pkg::rate_t pitch_rate_out
);
	import rate_ctrl_pkg::*;

	ctrl_state_e state;
	logic accept;
	logic go;
	logic all_seen;

	rate_t yaw_target_r;
	rate_t roll_target_r;
	rate_t pitch_target_r;
	rate_t yaw_actual_r;
	rate_t roll_actual_r;
	rate_t pitch_actual_r;

	rate_t yaw_pid_out;
	rate_t roll_pid_out;
	rate_t pitch_pid_out;
	logic yaw_ready;
	logic roll_ready;
	logic pitch_ready;
	logic yaw_seen;
	logic roll_seen;
	logic pitch_seen;

	assign accept = (state == WAITING) && start;
	assign all_seen = yaw_seen && roll_seen && pitch_seen;
	assign done = (state == COMPLETE);

	// Yaw and pitch IMU axes point opposite to the body frame
	always_ff @(posedge us_clk) begin
		if (accept) begin
			yaw_target_r <= yaw_target;
			roll_target_r <= roll_target;
			pitch_target_r <= pitch_target;
			yaw_actual_r <= -yaw_rotation;
			roll_actual_r <= roll_rotation;
			pitch_actual_r <= -pitch_rotation;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= WAITING;
			go <= 1'b0;
			yaw_seen <= 1'b0;
			roll_seen <= 1'b0;
			pitch_seen <= 1'b0;
			yaw_rate_out <= '0;
			roll_rate_out <= '0;
			pitch_rate_out <= '0;
		end else begin
			go <= accept;
			// Axes may report on different cycles
			if (accept) begin
				yaw_seen <= 1'b0;
				roll_seen <= 1'b0;
				pitch_seen <= 1'b0;
			end else begin
				yaw_seen <= yaw_seen || yaw_ready;
				roll_seen <= roll_seen || roll_ready;
				pitch_seen <= pitch_seen || pitch_ready;
			end
			case (state)
				WAITING: begin
					if (start)
						state <= RUNNING;
				end
				RUNNING: begin
					if (all_seen) begin
						yaw_rate_out <= yaw_pid_out;
						roll_rate_out <= roll_pid_out;
						pitch_rate_out <= pitch_pid_out;
						state <= COMPLETE;
					end
				end
				COMPLETE: state <= WAITING;
				default: state <= WAITING;
			endcase
		end
	end

	pid_axis yaw_pid (
		.us_clk(us_clk), .resetn(resetn), .go(go),
		.target(yaw_target_r), .actual(yaw_actual_r),
		.kp(yaw_kp), .ki(yaw_ki), .kd(yaw_kd), .clear_integ(clear_integ),
		.rate_out(yaw_pid_out), .ready(yaw_ready)
	);

	pid_axis roll_pid (
		.us_clk(us_clk), .resetn(resetn), .go(go),
		.target(roll_target_r), .actual(roll_actual_r),
		.kp(roll_kp), .ki(roll_ki), .kd(roll_kd), .clear_integ(clear_integ),
		.rate_out(roll_pid_out), .ready(roll_ready)
	);

	pid_axis pitch_pid (
		.us_clk(us_clk), .resetn(resetn), .go(go),
		.target(pitch_target_r), .actual(pitch_actual_r),
		.kp(pitch_kp), .ki(pitch_ki), .kd(pitch_kd), .clear_integ(clear_integ),
		.rate_out(pitch_pid_out), .ready(pitch_ready)
	);

endmodule

//--- source/pid_axis.sv
// One PID axis step taking five cycles from go to ready; gains are sampled at go, go is ignored while busy
`timescale 1ns/1ps

module pid_axis (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 go,
	input  rate_ctrl_pkg::rate_t target,
	input  rate_ctrl_pkg::rate_t actual,
	input  rate_ctrl_pkg::gain_t kp,
	input  rate_ctrl_pkg::gain_t ki,
	input  rate_ctrl_pkg::gain_t kd,
	input  logic                 clear_integ,
	output rate_ctrl_pkg::rate_t rate_out,
	output logic                 ready
);
	import rate_ctrl_pkg::*;

	pid_state_e state;
	logic start_step;

	err_t err_now;
	err_t err_r;
	err_t prev_err;
	logic signed [ERR_W:0] deriv;

	integ_t integ;
	integ_t integ_next;
	logic signed [INTEG_W:0] integ_sum;

	gain_t kp_r;
	gain_t ki_r;
	gain_t kd_r;

	// Shared multiplier operands
	integ_t mul_a;
	logic signed [GAIN_W:0] mul_b;
	prod_t product;
	prod_t acc;
	prod_t acc_base;
	rate_t sat_out;

	assign start_step = (state == IDLE) && go;
	assign err_now = err_t'(target) - err_t'(actual);

	// Integrator with symmetric saturation
	always_comb begin
		integ_sum = integ + err_now;
		if (integ_sum > INTEG_LIMIT)
			integ_next = integ_t'(INTEG_LIMIT);
		else if (integ_sum < -INTEG_LIMIT)
			integ_next = integ_t'(-INTEG_LIMIT);
		else
			integ_next = integ_t'(integ_sum);
	end

	// Clear wins over an update in the same cycle
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			integ <= '0;
			prev_err <= '0;
		end else if (clear_integ) begin
			integ <= '0;
			prev_err <= '0;
		end else if (start_step) begin
			integ <= integ_next;
			prev_err <= err_now;
		end
	end

	// One product per MUL state
	always_comb begin
		mul_a = '0;
		mul_b = '0;
		case (state)
			MUL_P: begin
				mul_a = integ_t'(err_r);
				mul_b = {1'b0, kp_r};
			end
			MUL_I: begin
				mul_a = integ;
				mul_b = {1'b0, ki_r};
			end
			MUL_D: begin
				mul_a = integ_t'(deriv);
				mul_b = {1'b0, kd_r};
			end
			default: begin
				mul_a = '0;
				mul_b = '0;
			end
		endcase
		product = mul_a * mul_b;
		acc_base = (state == MUL_P) ? '0 : acc;
	end

	always_ff @(posedge us_clk) begin
		if (start_step) begin
			err_r <= err_now;
			deriv <= err_now - prev_err;
			kp_r <= kp;
			ki_r <= ki;
			kd_r <= kd;
		end
		if (state == MUL_P || state == MUL_I || state == MUL_D)
			acc <= acc_base + (product >>> GAIN_SHIFT);
	end

	// Output clamp
	always_comb begin
		if (acc > prod_t'(RATE_LIMIT))
			sat_out = rate_t'(RATE_LIMIT);
		else if (acc < -prod_t'(RATE_LIMIT))
			sat_out = rate_t'(-RATE_LIMIT);
		else
			sat_out = rate_t'(acc);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= IDLE;
			rate_out <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				IDLE: begin
					if (go)
						state <= MUL_P;
				end
				MUL_P: state <= MUL_I;
				MUL_I: state <= MUL_D;
				MUL_D: state <= SUM;
				SUM: begin
					rate_out <= sat_out;
					ready <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- source/rate_ctrl_pkg.sv
// Shared widths, limits, APB register map and tuned reset gains; rates are signed 12.4 fixed point
package rate_ctrl_pkg;

	// Fixed-point layout of a rate
	localparam int RATE_W = 16;
	localparam int FRAC_W = 4;
	localparam int ERR_W = RATE_W + 1;
	localparam int INTEG_W = 24;
	localparam int GAIN_W = 8;
	// Signed operand times zero-extended gain
	localparam int PROD_W = INTEG_W + GAIN_W + 1;

	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	typedef logic signed [RATE_W-1:0] rate_t;
	typedef logic signed [ERR_W-1:0] err_t;
	typedef logic signed [INTEG_W-1:0] integ_t;
	typedef logic [GAIN_W-1:0] gain_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	localparam int GAIN_SHIFT = 4;
	// 250 deg/s in 12.4
	localparam int RATE_LIMIT = 250 << FRAC_W;
	localparam int INTEG_LIMIT = 1 << 20;

	// Byte addresses, one gain triple per axis
	localparam apb_addr_t REG_YAW_GAIN = 12'h000;
	localparam apb_addr_t REG_ROLL_GAIN = 12'h004;
	localparam apb_addr_t REG_PITCH_GAIN = 12'h008;
	localparam apb_addr_t REG_CTRL = 12'h00C;

	// Gains from flight tuning
	localparam gain_t YAW_KP_RST = 8'd51;
	localparam gain_t YAW_KI_RST = 8'd0;
	localparam gain_t YAW_KD_RST = 8'd5;
	localparam gain_t ROLL_KP_RST = 8'd5;
	localparam gain_t ROLL_KI_RST = 8'd3;
	localparam gain_t ROLL_KD_RST = 8'd4;
	localparam gain_t PITCH_KP_RST = 8'd5;
	localparam gain_t PITCH_KI_RST = 8'd3;
	localparam gain_t PITCH_KD_RST = 8'd4;

	typedef enum logic [2:0] {IDLE, MUL_P, MUL_I, MUL_D, SUM} pid_state_e;
	typedef enum logic [1:0] {WAITING, RUNNING, COMPLETE} ctrl_state_e;

endpackage
